// ==== common/axil_pkg.sv ====
package axil_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  localparam int NUM_MST = 2;
  localparam int NUM_SLV = 2;

  // Slave i owns the 4 KiB window that starts at i * RULE_BASE_STEP
  localparam logic [ADDR_WIDTH-1:0] RULE_MASK      = 32'hFFFF_F000;
  localparam logic [ADDR_WIDTH-1:0] RULE_BASE_STEP = 32'h0001_0000;

  localparam int NUM_REGS      = 4;
  localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);
  localparam int REG_IDX_LSB   = $clog2(STRB_WIDTH);

  typedef logic [$clog2(NUM_MST)-1:0] mst_idx_t;
  typedef logic [$clog2(NUM_SLV)-1:0] slv_idx_t;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            prot;
  } axil_aw_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    resp_t resp;
  } axil_b_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            prot;
  } axil_ar_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    resp_t                 resp;
  } axil_r_t;

  // AW and W always transfer together, so they share one arbiter payload
  typedef struct packed {
    axil_aw_t aw;
    axil_w_t  w;
  } axil_wreq_t;

  typedef struct packed {
    logic     aw_valid;
    axil_aw_t aw;
    logic     w_valid;
    axil_w_t  w;
    logic     b_ready;
    logic     ar_valid;
    axil_ar_t ar;
    logic     r_ready;
  } axil_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    axil_b_t b;
    logic    ar_ready;
    logic    r_valid;
    axil_r_t r;
  } axil_rsp_t;

endpackage

// ==== axil_xbar/axil_addr_decode.sv ====
`timescale 1ns/1ps

module axil_addr_decode import axil_pkg::*; (
  input  logic [ADDR_WIDTH-1:0] addr,
  output slv_idx_t              slv_idx,
  output logic                  dec_err
);

  logic [ADDR_WIDTH-1:0] masked_addr;

  assign masked_addr = addr & RULE_MASK;

  // Rules are checked in slave order and the first hit wins
  always_comb begin
    logic                  hit;
    logic [ADDR_WIDTH-1:0] base;
    hit     = 1'b0;
    slv_idx = '0;
    for (int i = 0; i < NUM_SLV; i++) begin
      base = ADDR_WIDTH'(i) * RULE_BASE_STEP;
      if (!hit && (masked_addr == base)) begin
        hit     = 1'b1;
        slv_idx = slv_idx_t'(i);
      end
    end
    // No window claims the address, so the router answers with DECERR
    dec_err = !hit;
  end

endmodule

// ==== axil_xbar/axil_rr_arbiter.sv ====
`timescale 1ns/1ps

module axil_rr_arbiter import axil_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic [NUM_MST-1:0] req,
  input  payload_t           payload [NUM_MST],
  input  logic               grant_en,
  output logic               valid,
  output payload_t           data,
  output mst_idx_t           idx,
  input  logic               ready
);

  // Master with the highest priority in the next round
  mst_idx_t prio_q;
  logic     lock_q;
  mst_idx_t lock_idx_q;

  mst_idx_t sel;
  logic     found;

  always_comb begin
    mst_idx_t cand;
    sel   = lock_idx_q;
    found = lock_q;
    // Scan starts at the priority pointer and wraps around once
    for (int k = 0; k < NUM_MST; k++) begin
      cand = mst_idx_t'((int'(prio_q) + k) % NUM_MST);
      if (!found && req[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
    end
  end

  assign valid = grant_en && found;
  assign data  = payload[sel];
  assign idx   = sel;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (valid && ready) begin
      prio_q <= mst_idx_t'((int'(sel) + 1) % NUM_MST);
      lock_q <= 1'b0;
    end else if (valid) begin
      // Hold the winner so its payload stays put until the handshake
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end
  end

endmodule

// ==== axil_xbar/axil_txn_route.sv ====
`timescale 1ns/1ps

module axil_txn_route import axil_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               wr_valid,
  input  axil_wreq_t         wr_data,
  input  mst_idx_t           wr_idx,
  input  slv_idx_t           wr_slv,
  input  logic               wr_dec_err,
  output logic               wr_ready,
  output logic               wr_grant_en,
  input  logic               rd_valid,
  input  axil_ar_t           rd_data,
  input  mst_idx_t           rd_idx,
  input  slv_idx_t           rd_slv,
  input  logic               rd_dec_err,
  output logic               rd_ready,
  output logic               rd_grant_en,
  output axil_rsp_t          mst_rsp [NUM_MST],
  input  logic [NUM_MST-1:0] mst_b_ready,
  input  logic [NUM_MST-1:0] mst_r_ready,
  output axil_req_t          slv_req [NUM_SLV],
  input  axil_rsp_t          slv_rsp [NUM_SLV]
);

  // State of the single transaction in flight per direction
  logic     wr_busy_q, wr_err_q;
  mst_idx_t wr_mst_q;
  slv_idx_t wr_slv_q;
  logic     rd_busy_q, rd_err_q;
  mst_idx_t rd_mst_q;
  slv_idx_t rd_slv_q;

  logic    wr_rsp_valid, rd_rsp_valid;
  axil_b_t wr_rsp;
  axil_r_t rd_rsp;

  assign wr_grant_en = !wr_busy_q;
  assign rd_grant_en = !rd_busy_q;

  // A failed decode is absorbed here without touching any slave
  assign wr_ready = wr_dec_err || (slv_rsp[wr_slv].aw_ready && slv_rsp[wr_slv].w_ready);
  assign rd_ready = rd_dec_err || slv_rsp[rd_slv].ar_ready;

  assign wr_rsp_valid = wr_busy_q && (wr_err_q || slv_rsp[wr_slv_q].b_valid);
  assign rd_rsp_valid = rd_busy_q && (rd_err_q || slv_rsp[rd_slv_q].r_valid);
  assign wr_rsp = wr_err_q ? axil_b_t'{resp: RESP_DECERR} : slv_rsp[wr_slv_q].b;
  assign rd_rsp = rd_err_q ? axil_r_t'{data: '0, resp: RESP_DECERR} : slv_rsp[rd_slv_q].r;

  always_comb begin
    for (int s = 0; s < NUM_SLV; s++) begin
      slv_req[s]          = '0;
      slv_req[s].aw_valid = wr_valid && !wr_dec_err && (wr_slv == slv_idx_t'(s));
      slv_req[s].w_valid  = slv_req[s].aw_valid;
      slv_req[s].aw       = wr_data.aw;
      slv_req[s].w        = wr_data.w;
      slv_req[s].b_ready  = wr_busy_q && !wr_err_q && (wr_slv_q == slv_idx_t'(s)) &&
                            mst_b_ready[wr_mst_q];
      slv_req[s].ar_valid = rd_valid && !rd_dec_err && (rd_slv == slv_idx_t'(s));
      slv_req[s].ar       = rd_data;
      slv_req[s].r_ready  = rd_busy_q && !rd_err_q && (rd_slv_q == slv_idx_t'(s)) &&
                            mst_r_ready[rd_mst_q];
    end
  end

  // Only the granted master sees a ready, only the owner sees a response
  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      mst_rsp[m].aw_ready = wr_valid && wr_ready && (wr_idx == mst_idx_t'(m));
      mst_rsp[m].w_ready  = mst_rsp[m].aw_ready;
      mst_rsp[m].b_valid  = wr_rsp_valid && (wr_mst_q == mst_idx_t'(m));
      mst_rsp[m].b        = wr_rsp;
      mst_rsp[m].ar_ready = rd_valid && rd_ready && (rd_idx == mst_idx_t'(m));
      mst_rsp[m].r_valid  = rd_rsp_valid && (rd_mst_q == mst_idx_t'(m));
      mst_rsp[m].r        = rd_rsp;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_busy_q <= 1'b0;
      wr_err_q  <= 1'b0;
      wr_mst_q  <= '0;
      wr_slv_q  <= '0;
    end else if (wr_valid && wr_ready) begin
      wr_busy_q <= 1'b1;
      wr_err_q  <= wr_dec_err;
      wr_mst_q  <= wr_idx;
      wr_slv_q  <= wr_slv;
    end else if (wr_rsp_valid && mst_b_ready[wr_mst_q]) begin
      wr_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      rd_busy_q <= 1'b0;
      rd_err_q  <= 1'b0;
      rd_mst_q  <= '0;
      rd_slv_q  <= '0;
    end else if (rd_valid && rd_ready) begin
      rd_busy_q <= 1'b1;
      rd_err_q  <= rd_dec_err;
      rd_mst_q  <= rd_idx;
      rd_slv_q  <= rd_slv;
    end else if (rd_rsp_valid && mst_r_ready[rd_mst_q]) begin
      rd_busy_q <= 1'b0;
    end
  end

endmodule

// ==== rtl/axil_reg_slave.sv ====
`timescale 1ns/1ps

module axil_reg_slave import axil_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n,
  input  axil_req_t req,
  output axil_rsp_t rsp
);

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

  logic    b_valid_q, r_valid_q;
  axil_b_t b_q;
  axil_r_t r_q;

  logic                     wr_hs, rd_hs;
  logic                     wr_in_range, rd_in_range;
  logic [REG_IDX_WIDTH-1:0] wr_reg, rd_reg;

  assign wr_hs = req.aw_valid && req.w_valid && !b_valid_q;
  assign rd_hs = req.ar_valid && !r_valid_q;

  // Only the first NUM_REGS words of the window are backed by registers
  assign wr_in_range = (req.aw.addr & ~RULE_MASK) < ADDR_WIDTH'(NUM_REGS * STRB_WIDTH);
  assign rd_in_range = (req.ar.addr & ~RULE_MASK) < ADDR_WIDTH'(NUM_REGS * STRB_WIDTH);
  assign wr_reg = req.aw.addr[REG_IDX_LSB +: REG_IDX_WIDTH];
  assign rd_reg = req.ar.addr[REG_IDX_LSB +: REG_IDX_WIDTH];

  assign rsp.aw_ready = !b_valid_q;
  assign rsp.w_ready  = !b_valid_q;
  assign rsp.b_valid  = b_valid_q;
  assign rsp.b        = b_q;
  assign rsp.ar_ready = !r_valid_q;
  assign rsp.r_valid  = r_valid_q;
  assign rsp.r        = r_q;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_hs && wr_in_range) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (req.w.strb[b]) begin
          regs_q[wr_reg][8*b +: 8] <= req.w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (req.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (req.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payloads are captured only on the request handshake
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      b_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      r_q.data <= rd_in_range ? regs_q[rd_reg] : '0;
      r_q.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== rtl/axil_xbar_top.sv ====
`timescale 1ns/1ps

module axil_xbar_top import axil_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n,
  input  axil_req_t mst_req [NUM_MST],
  output axil_rsp_t mst_rsp [NUM_MST]
);

  logic [NUM_MST-1:0] wr_req, rd_req;
  logic [NUM_MST-1:0] mst_b_ready, mst_r_ready;
  axil_wreq_t         wr_payload [NUM_MST];
  axil_ar_t           rd_payload [NUM_MST];

  logic       wr_valid, wr_ready, wr_grant_en, wr_dec_err;
  axil_wreq_t wr_data;
  mst_idx_t   wr_idx;
  slv_idx_t   wr_slv;

  logic       rd_valid, rd_ready, rd_grant_en, rd_dec_err;
  axil_ar_t   rd_data;
  mst_idx_t   rd_idx;
  slv_idx_t   rd_slv;

  axil_req_t  slv_req [NUM_SLV];
  axil_rsp_t  slv_rsp [NUM_SLV];

  // A write competes only once both AW and W are offered
  for (genvar m = 0; m < NUM_MST; m++) begin : gen_mst
    assign wr_req[m]      = mst_req[m].aw_valid && mst_req[m].w_valid;
    assign wr_payload[m]  = '{aw: mst_req[m].aw, w: mst_req[m].w};
    assign rd_req[m]      = mst_req[m].ar_valid;
    assign rd_payload[m]  = mst_req[m].ar;
    assign mst_b_ready[m] = mst_req[m].b_ready;
    assign mst_r_ready[m] = mst_req[m].r_ready;
  end

  axil_rr_arbiter #(
    .payload_t (axil_wreq_t)
  ) u_wr_arb (
    .clk_i    (clk_i),
    .arst_n   (arst_n),
    .req      (wr_req),
    .payload  (wr_payload),
    .grant_en (wr_grant_en),
    .valid    (wr_valid),
    .data     (wr_data),
    .idx      (wr_idx),
    .ready    (wr_ready)
  );

  axil_rr_arbiter #(
    .payload_t (axil_ar_t)
  ) u_rd_arb (
    .clk_i    (clk_i),
    .arst_n   (arst_n),
    .req      (rd_req),
    .payload  (rd_payload),
    .grant_en (rd_grant_en),
    .valid    (rd_valid),
    .data     (rd_data),
    .idx      (rd_idx),
    .ready    (rd_ready)
  );

  axil_addr_decode u_wr_dec (
    .addr    (wr_data.aw.addr),
    .slv_idx (wr_slv),
    .dec_err (wr_dec_err)
  );

  axil_addr_decode u_rd_dec (
    .addr    (rd_data.addr),
    .slv_idx (rd_slv),
    .dec_err (rd_dec_err)
  );

  axil_txn_route u_route (
    .clk_i       (clk_i),
    .arst_n      (arst_n),
    .wr_valid    (wr_valid),
    .wr_data     (wr_data),
    .wr_idx      (wr_idx),
    .wr_slv      (wr_slv),
    .wr_dec_err  (wr_dec_err),
    .wr_ready    (wr_ready),
    .wr_grant_en (wr_grant_en),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_idx      (rd_idx),
    .rd_slv      (rd_slv),
    .rd_dec_err  (rd_dec_err),
    .rd_ready    (rd_ready),
    .rd_grant_en (rd_grant_en),
    .mst_rsp     (mst_rsp),
    .mst_b_ready (mst_b_ready),
    .mst_r_ready (mst_r_ready),
    .slv_req     (slv_req),
    .slv_rsp     (slv_rsp)
  );

  for (genvar s = 0; s < NUM_SLV; s++) begin : gen_slv
    axil_reg_slave u_slv (
      .clk_i  (clk_i),
      .arst_n (arst_n),
      .req    (slv_req[s]),
      .rsp    (slv_rsp[s])
    );
  end

endmodule

// ==== testbench/axil_xbar_checker.sv ====
`timescale 1ns/1ps

module axil_xbar_checker import axil_pkg::*; (
  input logic      clk_i,
  input logic      arst_n,
  input axil_req_t mst_req [NUM_MST],
  input axil_rsp_t mst_rsp [NUM_MST]
);

  for (genvar m = 0; m < NUM_MST; m++) begin : gen_mst
    // A raised request valid has to wait for its ready
    aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
      mst_req[m].aw_valid && !mst_rsp[m].aw_ready |=> mst_req[m].aw_valid)
      else $error("master %0d dropped aw_valid before aw_ready", m);
    w_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
      mst_req[m].w_valid && !mst_rsp[m].w_ready |=> mst_req[m].w_valid)
      else $error("master %0d dropped w_valid before w_ready", m);
    ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
      mst_req[m].ar_valid && !mst_rsp[m].ar_ready |=> mst_req[m].ar_valid)
      else $error("master %0d dropped ar_valid before ar_ready", m);

    // Responses under back-pressure keep their valid and payload
    b_stable: assert property (@(posedge clk_i) disable iff (!arst_n)
      mst_rsp[m].b_valid && !mst_req[m].b_ready |=>
        mst_rsp[m].b_valid && $stable(mst_rsp[m].b))
      else $error("B response to master %0d changed while stalled", m);
    r_stable: assert property (@(posedge clk_i) disable iff (!arst_n)
      mst_rsp[m].r_valid && !mst_req[m].r_ready |=>
        mst_rsp[m].r_valid && $stable(mst_rsp[m].r))
      else $error("R response to master %0d changed while stalled", m);

    quiet_in_reset: assert property (@(posedge clk_i)
      !arst_n |-> !mst_rsp[m].b_valid && !mst_rsp[m].r_valid)
      else $error("response valid to master %0d during reset", m);
  end

endmodule

bind axil_xbar_top axil_xbar_checker u_checker (.*);

// ==== testbench/tb_axil_xbar.sv ====
`timescale 1ns/1ps

module tb_axil_xbar import axil_pkg::*; ();

  localparam int CYCLE_LIMIT = 2000;

  logic      clk_i;
  logic      arst_n;
  axil_req_t mst_req [NUM_MST];
  axil_rsp_t mst_rsp [NUM_MST];

  // Expected register contents as the write rules leave them
  logic [DATA_WIDTH-1:0] exp_regs [NUM_SLV][NUM_REGS];
  logic [31:0]           rng_state = 32'd57;
  int                    cycle_cnt = 0;
  int                    chk_cnt = 0;
  int                    err_cnt = 0;
  int                    aw_hs_cycle [NUM_MST];

  axil_xbar_top u_dut (
    .clk_i   (clk_i),
    .arst_n  (arst_n),
    .mst_req (mst_req),
    .mst_rsp (mst_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_strb(input logic [DATA_WIDTH-1:0] old,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] res;
    res = old;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Register i of slave s sits at word i of window s
  function automatic logic [ADDR_WIDTH-1:0] reg_addr(input int s, input int i);
    return ADDR_WIDTH'(s) * 32'h0001_0000 + ADDR_WIDTH'(i * 4);
  endfunction

  task automatic check_b(input mst_idx_t m, input axil_b_t got, input axil_b_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR mst_rsp[%0d].b: got resp 0x%0h, expected 0x%0h", m, got.resp, exp.resp);
    end
  endtask

  task automatic check_r(input mst_idx_t m, input axil_r_t got, input axil_r_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR mst_rsp[%0d].r: got data 0x%08h resp 0x%0h, expected data 0x%08h resp 0x%0h",
               m, got.data, got.resp, exp.data, exp.resp);
    end
  endtask

  task automatic report_problem(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("%-18s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    arst_n <= 1'b0;
    for (int m = 0; m < NUM_MST; m++) begin
      mst_req[m]         <= '0;
      mst_req[m].b_ready <= 1'b1;
      mst_req[m].r_ready <= 1'b1;
    end
    repeat (8) @(posedge clk_i);
    arst_n <= 1'b1;
    for (int s = 0; s < NUM_SLV; s++) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        exp_regs[s][i] = '0;
      end
    end
  endtask

  // With stall above zero, b_ready stays low for that many cycles after B appears
  task automatic axil_write(input mst_idx_t m, input logic [ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb,
      input int stall, output axil_b_t b);
    @(posedge clk_i);
    mst_req[m].aw_valid <= 1'b1;
    mst_req[m].w_valid  <= 1'b1;
    mst_req[m].aw       <= '{addr: addr, prot: 3'b000};
    mst_req[m].w        <= '{data: data, strb: strb};
    mst_req[m].b_ready  <= (stall == 0);
    do @(negedge clk_i); while (!mst_rsp[m].aw_ready);
    if (!mst_rsp[m].w_ready) begin
      report_problem($sformatf("W ready to master %0d stayed low while AW ready was high", m));
    end
    aw_hs_cycle[m] = cycle_cnt;
    @(posedge clk_i);
    mst_req[m].aw_valid <= 1'b0;
    mst_req[m].w_valid  <= 1'b0;
    do @(negedge clk_i); while (!mst_rsp[m].b_valid);
    b = mst_rsp[m].b;
    repeat (stall) begin
      @(negedge clk_i);
      if (!mst_rsp[m].b_valid) begin
        report_problem($sformatf("B valid to master %0d dropped while b_ready was low", m));
      end
      check_b(m, mst_rsp[m].b, b);
    end
    if (stall > 0) begin
      @(posedge clk_i);
      mst_req[m].b_ready <= 1'b1;
    end
    @(posedge clk_i);
  endtask

  task automatic axil_read(input mst_idx_t m, input logic [ADDR_WIDTH-1:0] addr,
      output axil_r_t r);
    @(posedge clk_i);
    mst_req[m].ar_valid <= 1'b1;
    mst_req[m].ar       <= '{addr: addr, prot: 3'b000};
    do @(negedge clk_i); while (!mst_rsp[m].ar_ready);
    @(posedge clk_i);
    mst_req[m].ar_valid <= 1'b0;
    do @(negedge clk_i); while (!mst_rsp[m].r_valid);
    r = mst_rsp[m].r;
    @(posedge clk_i);
  endtask

  task automatic test_reset_values();
    int      errs;
    axil_r_t r;
    errs = err_cnt;
    for (int s = 0; s < NUM_SLV; s++) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        axil_read(mst_idx_t'(i), reg_addr(s, i), r);
        check_r(mst_idx_t'(i), r, axil_r_t'{data: '0, resp: RESP_OKAY});
      end
    end
    end_test("reset_values", errs);
  endtask

  task automatic test_write_readback();
    int                    errs;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    axil_b_t               b;
    axil_r_t               r;
    errs = err_cnt;
    for (int m = 0; m < NUM_MST; m++) begin
      for (int s = 0; s < NUM_SLV; s++) begin
        for (int i = 0; i < NUM_REGS; i++) begin
          data = next_random();
          strb = STRB_WIDTH'(next_random());
          if (strb == '0 || strb == '1) begin
            strb = 4'b0110;
          end
          axil_write(mst_idx_t'(m), reg_addr(s, i), data, strb, 0, b);
          check_b(mst_idx_t'(m), b, axil_b_t'{resp: RESP_OKAY});
          exp_regs[s][i] = merge_strb(exp_regs[s][i], data, strb);
          // Read back through the other master
          axil_read(mst_idx_t'(m + 1), reg_addr(s, i), r);
          check_r(mst_idx_t'(m + 1), r, axil_r_t'{data: exp_regs[s][i], resp: RESP_OKAY});
        end
      end
    end
    end_test("write_readback", errs);
  endtask

  task automatic test_error_responses();
    int                    errs;
    logic [ADDR_WIDTH-1:0] bad_addr [2];
    axil_b_t               b;
    axil_r_t               r;
    errs = err_cnt;
    bad_addr[0] = 32'h0002_0000;
    bad_addr[1] = 32'h0001_1004;
    for (int k = 0; k < 2; k++) begin
      axil_write(mst_idx_t'(k), bad_addr[k], next_random(), '1, 0, b);
      check_b(mst_idx_t'(k), b, axil_b_t'{resp: RESP_DECERR});
      axil_read(mst_idx_t'(k + 1), bad_addr[k], r);
      check_r(mst_idx_t'(k + 1), r, axil_r_t'{data: '0, resp: RESP_DECERR});
    end
    // Word 4 of each window is past the last register
    for (int s = 0; s < NUM_SLV; s++) begin
      axil_write(mst_idx_t'(s), reg_addr(s, NUM_REGS), next_random(), '1, 0, b);
      check_b(mst_idx_t'(s), b, axil_b_t'{resp: RESP_SLVERR});
      axil_read(mst_idx_t'(s), reg_addr(s, NUM_REGS), r);
      check_r(mst_idx_t'(s), r, axil_r_t'{data: '0, resp: RESP_SLVERR});
    end
    for (int s = 0; s < NUM_SLV; s++) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        axil_read(mst_idx_t'(s), reg_addr(s, i), r);
        check_r(mst_idx_t'(s), r, axil_r_t'{data: exp_regs[s][i], resp: RESP_OKAY});
      end
    end
    end_test("error_responses", errs);
  endtask

  task automatic test_arbitration();
    int                    errs;
    logic [DATA_WIDTH-1:0] d0, d1;
    axil_b_t               b0, b1;
    axil_r_t               r;
    errs = err_cnt;
    apply_reset();
    d0 = next_random();
    d1 = next_random();
    fork
      axil_write(mst_idx_t'(0), reg_addr(0, 2), d0, '1, 0, b0);
      axil_write(mst_idx_t'(1), reg_addr(0, 2), d1, '1, 0, b1);
    join
    check_b(mst_idx_t'(0), b0, axil_b_t'{resp: RESP_OKAY});
    check_b(mst_idx_t'(1), b1, axil_b_t'{resp: RESP_OKAY});
    if (aw_hs_cycle[0] >= aw_hs_cycle[1]) begin
      report_problem("Master 1 was granted before master 0 right after reset");
    end
    // Master 0 lands first, so master 1's value is the one that stays
    exp_regs[0][2] = d1;
    axil_read(mst_idx_t'(0), reg_addr(0, 2), r);
    check_r(mst_idx_t'(0), r, axil_r_t'{data: exp_regs[0][2], resp: RESP_OKAY});
    d0 = next_random();
    d1 = next_random();
    fork
      axil_write(mst_idx_t'(0), reg_addr(1, 0), d0, '1, 0, b0);
      axil_write(mst_idx_t'(1), reg_addr(1, 3), d1, '1, 0, b1);
    join
    check_b(mst_idx_t'(0), b0, axil_b_t'{resp: RESP_OKAY});
    check_b(mst_idx_t'(1), b1, axil_b_t'{resp: RESP_OKAY});
    exp_regs[1][0] = d0;
    exp_regs[1][3] = d1;
    axil_read(mst_idx_t'(1), reg_addr(1, 0), r);
    check_r(mst_idx_t'(1), r, axil_r_t'{data: exp_regs[1][0], resp: RESP_OKAY});
    axil_read(mst_idx_t'(0), reg_addr(1, 3), r);
    check_r(mst_idx_t'(0), r, axil_r_t'{data: exp_regs[1][3], resp: RESP_OKAY});
    end_test("arbitration", errs);
  endtask

  task automatic test_b_backpressure();
    int                    errs;
    int                    stall;
    logic                  wr_done;
    logic [DATA_WIDTH-1:0] data;
    axil_b_t               b;
    axil_r_t               r;
    errs = err_cnt;
    stall = 4 + int'(next_random() % 8);
    data = next_random();
    wr_done = 1'b0;
    fork
      begin
        axil_write(mst_idx_t'(0), reg_addr(0, 0), data, '1, stall, b);
        wr_done = 1'b1;
      end
      begin
        repeat (3) @(posedge clk_i);
        axil_read(mst_idx_t'(1), reg_addr(0, 2), r);
        if (wr_done) begin
          report_problem("The read of master 1 waited for the stalled write response");
        end
        check_r(mst_idx_t'(1), r, axil_r_t'{data: exp_regs[0][2], resp: RESP_OKAY});
      end
    join
    check_b(mst_idx_t'(0), b, axil_b_t'{resp: RESP_OKAY});
    exp_regs[0][0] = data;
    axil_read(mst_idx_t'(1), reg_addr(0, 0), r);
    check_r(mst_idx_t'(1), r, axil_r_t'{data: exp_regs[0][0], resp: RESP_OKAY});
    end_test("b_backpressure", errs);
  endtask

  initial begin
    arst_n = 1'b0;
    for (int m = 0; m < NUM_MST; m++) begin
      mst_req[m]         = '0;
      mst_req[m].b_ready = 1'b1;
      mst_req[m].r_ready = 1'b1;
    end
    apply_reset();
    test_reset_values();
    test_write_readback();
    test_error_responses();
    test_arbitration();
    test_b_backpressure();
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
common/axil_pkg.sv
axil_xbar/axil_addr_decode.sv
axil_xbar/axil_rr_arbiter.sv
axil_xbar/axil_txn_route.sv
rtl/axil_reg_slave.sv
rtl/axil_xbar_top.sv
testbench/axil_xbar_checker.sv
testbench/tb_axil_xbar.sv

// ==== Bender.yml ====
package:
  name: axil_xbar

sources:
  - common/axil_pkg.sv
  - axil_xbar/axil_addr_decode.sv
  - axil_xbar/axil_rr_arbiter.sv
  - axil_xbar/axil_txn_route.sv
  - rtl/axil_reg_slave.sv
  - rtl/axil_xbar_top.sv
  - target: test
    files:
      - testbench/axil_xbar_checker.sv
      - testbench/tb_axil_xbar.sv
